/* logic/fp16_pkg.sv */
package fp16_pkg;

    localparam int EXP_W = 5;   // exponent field width
    localparam int MAN_W = 10;  // stored fraction bits, hidden one implied

    // half precision word, sign on top
    typedef struct packed {
        logic             sign;      // 1 = negative
        logic [EXP_W-1:0] exponent;  // biased by EXP_BIAS
        logic [MAN_W-1:0] mantissa;  // fraction below the hidden one
    } float16_t;

    localparam int EXP_BIAS = 15;  // exponent offset
    localparam int EXP_MAX  = 31;  // all ones, reserved for infinity

    localparam float16_t FP_ONE  = 16'h3C00;  // 1.0
    localparam float16_t FP_ZERO = 16'h0000;  // plus zero
    localparam float16_t FP_INF  = 16'h7C00;  // plus infinity, sign or'd in by user

    // Both arithmetic units register their result, so these are also the
    // number of flop stages between operand and result.
    localparam int MUL_STAGES = 2;  // fp16_mul latency
    localparam int ADD_STAGES = 3;  // fp16_add latency

endpackage

/* logic/vec_pkg.sv */
package vec_pkg;

    localparam int VEC_LEN = 3;  // x, y, z

    // element 0 sits in the low bits
    typedef fp16_pkg::float16_t [VEC_LEN-1:0] vec3_t;

    // one datapath, op picks factor and result path
    typedef enum logic [1:0] {
        op_scale     = 2'd0,  // a * b per element
        op_translate = 2'd1,  // a + b per element
        op_dot       = 2'd2,  // signed dot product
        op_dot2      = 2'd3   // dot product doubled
    } vec_op_t;

    typedef struct packed {
        vec_op_t            op;    // what to compute
        logic [VEC_LEN-1:0] sign;  // negate b_i before multiply, dot ops only
        vec3_t              a;     // first operand
        vec3_t              b;     // second operand
    } vec_req_t;

    typedef struct packed {
        vec3_t              vec;     // scale and translate result
        fp16_pkg::float16_t scalar;  // dot and dot2 result
    } vec_res_t;

    localparam int REDUCE_LAYERS = 3;  // adder layers after the multipliers

    // request in to result out, in clock edges
    localparam int UNIT_LATENCY = fp16_pkg::MUL_STAGES
                                + REDUCE_LAYERS * fp16_pkg::ADD_STAGES;

endpackage

/* logic/fp16_mul.sv */
module fp16_mul (
    input  logic               clk,
    input  logic               rst_n,
    input  fp16_pkg::float16_t a,
    input  fp16_pkg::float16_t b,
    output fp16_pkg::float16_t y
);

    logic        s1_zero;  // either operand reads as zero
    logic        s1_sign;  // product sign
    logic [5:0]  s1_exp;   // sum of biased exponents with the bias in twice
    logic [21:0] s1_prod;  // 1.m times 1.m with top bit at 21 or 20

    logic signed [7:0]  exp_adj;  // rebiased exponent that may go negative
    logic [9:0]         man_n;    // truncated normalized fraction
    fp16_pkg::float16_t y_next;

    // stage 1 multiply significands and add exponents
    always_ff @(posedge clk) begin
        s1_zero <= (a.exponent == '0) || (b.exponent == '0);  // no subnormals
        s1_sign <= a.sign ^ b.sign;
        s1_exp  <= {1'b0, a.exponent} + {1'b0, b.exponent};
        s1_prod <= 22'({1'b1, a.mantissa}) * 22'({1'b1, b.mantissa});  // 11x11 unsigned
    end

    // stage 2 one bit normalize
    // product of two values in [1,2) lies in [1,4) and needs at most one shift
    assign exp_adj = 8'(s1_exp) + 8'(s1_prod[21]) - 8'(fp16_pkg::EXP_BIAS);
    assign man_n   = s1_prod[21] ? s1_prod[20:11] : s1_prod[19:10];  // drop hidden one

    always_comb begin
        y_next = fp16_pkg::FP_ZERO;
        if (s1_zero || exp_adj <= 0) begin
            y_next = fp16_pkg::FP_ZERO;  // zero operand or underflow gives plus zero
        end else if (exp_adj >= fp16_pkg::EXP_MAX) begin
            y_next      = fp16_pkg::FP_INF;  // overflow saturates to infinity
            y_next.sign = s1_sign;
        end else begin
            y_next.sign     = s1_sign;
            y_next.exponent = exp_adj[4:0];
            y_next.mantissa = man_n;        // truncated with low bits dropped
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= fp16_pkg::FP_ZERO;
        end else begin
            y <= y_next;
        end
    end

endmodule

/* logic/fp16_add.sv */
module fp16_add (
    input  logic               clk,
    input  logic               rst_n,
    input  fp16_pkg::float16_t a,
    input  fp16_pkg::float16_t b,
    output fp16_pkg::float16_t y
);

    // significands carry the hidden one at bit 13 and 3 guard bits below
    logic               a_big;   // |a| >= |b|
    fp16_pkg::float16_t hi;      // larger magnitude
    fp16_pkg::float16_t lo;      // smaller magnitude
    logic [13:0]        hi_sig;
    logic [13:0]        lo_sig;
    logic [4:0]         shift;   // exponent difference

    logic               s1_sign;   // result sign follows larger operand
    logic               s1_sub;    // signs differ
    logic [4:0]         s1_exp;
    logic [13:0]        s1_big;
    logic [13:0]        s1_small;  // already aligned

    logic               s2_sign;
    logic [4:0]         s2_exp;
    logic [14:0]        s2_sum;    // bit 14 holds the carry

    logic [3:0]         lz;        // leading zeros of s2_sum
    logic [14:0]        norm;      // hidden one moved to bit 14
    logic signed [7:0]  exp_adj;
    fp16_pkg::float16_t y_next;

    function automatic logic [3:0] lead_zeros(input logic [14:0] v);
        logic [3:0] n;
        n = 4'd14;  // all zero case is caught outside
        for (int i = 0; i < 15; i++) begin
            if (v[i]) begin
                n = 4'(14 - i);  // highest set bit wins
            end
        end
        return n;
    endfunction

    // stage 1 swap and align
    assign a_big  = {a.exponent, a.mantissa} >= {b.exponent, b.mantissa};
    assign hi     = a_big ? a : b;
    assign lo     = a_big ? b : a;
    assign hi_sig = (hi.exponent != '0) ? {1'b1, hi.mantissa, 3'b000} : '0;  // exp 0 is zero
    assign lo_sig = (lo.exponent != '0) ? {1'b1, lo.mantissa, 3'b000} : '0;
    assign shift  = hi.exponent - lo.exponent;

    always_ff @(posedge clk) begin
        s1_sign  <= hi.sign;
        s1_sub   <= a.sign ^ b.sign;
        s1_exp   <= hi.exponent;
        s1_big   <= hi_sig;
        s1_small <= lo_sig >> shift;  // bits past the guards are lost
    end

    // stage 2 magnitude add or subtract
    // small never exceeds big, so the difference stays non negative
    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_exp  <= s1_exp;
        if (s1_sub) begin
            s2_sum <= {1'b0, s1_big} - {1'b0, s1_small};
        end else begin
            s2_sum <= {1'b0, s1_big} + {1'b0, s1_small};
        end
    end

    // stage 3 normalize
    assign lz      = lead_zeros(s2_sum);
    assign norm    = s2_sum << lz;
    assign exp_adj = 8'(s2_exp) + 8'd1 - 8'(lz);  // carry out gives lz 0, exp + 1

    always_comb begin
        y_next = fp16_pkg::FP_ZERO;
        if (s2_sum == '0 || exp_adj <= 0) begin
            y_next = fp16_pkg::FP_ZERO;  // exact cancel or underflow
        end else if (exp_adj >= fp16_pkg::EXP_MAX) begin
            y_next      = fp16_pkg::FP_INF;
            y_next.sign = s2_sign;
        end else begin
            y_next.sign     = s2_sign;
            y_next.exponent = exp_adj[4:0];
            y_next.mantissa = norm[13:4];   // truncate guards
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= fp16_pkg::FP_ZERO;
        end else begin
            y <= y_next;
        end
    end

endmodule

/* logic/vec_product_stage.sv */
module vec_product_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  vec_pkg::vec_req_t req,
    output logic              prod_valid,
    output vec_pkg::vec_op_t  prod_op,
    output vec_pkg::vec3_t    prod,
    output vec_pkg::vec3_t    addend
);

    vec_pkg::vec3_t   factor;                           // second multiplier input per lane
    logic             valid_pipe [fp16_pkg::MUL_STAGES];
    vec_pkg::vec_op_t op_pipe    [fp16_pkg::MUL_STAGES];
    vec_pkg::vec3_t   b_pipe     [fp16_pkg::MUL_STAGES];

    // pick the factor per op
    always_comb begin
        for (int i = 0; i < vec_pkg::VEC_LEN; i++) begin
            case (req.op)
                vec_pkg::op_scale:     factor[i] = req.b[i];          // mask ignored
                vec_pkg::op_translate: factor[i] = fp16_pkg::FP_ONE;  // a * 1 passes a
                default: begin                                        // dot and dot2
                    factor[i]      = req.b[i];
                    factor[i].sign = req.b[i].sign ^ req.sign[i];     // sign flip
                end
            endcase
        end
    end

    for (genvar i = 0; i < vec_pkg::VEC_LEN; i++) begin : g_lane
        fp16_mul u_mul (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (req.a[i]),
            .b     (factor[i]),
            .y     (prod[i])
        );
    end

    // valid follows the multipliers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fp16_pkg::MUL_STAGES; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= in_valid;
            for (int i = 1; i < fp16_pkg::MUL_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // op and raw b ride alongside, b is the translate addend
    always_ff @(posedge clk) begin
        op_pipe[0] <= req.op;
        b_pipe[0]  <= req.b;
        for (int i = 1; i < fp16_pkg::MUL_STAGES; i++) begin
            op_pipe[i] <= op_pipe[i-1];
            b_pipe[i]  <= b_pipe[i-1];
        end
    end

    assign prod_valid = valid_pipe[fp16_pkg::MUL_STAGES-1];
    assign prod_op    = op_pipe[fp16_pkg::MUL_STAGES-1];
    assign addend     = b_pipe[fp16_pkg::MUL_STAGES-1];

endmodule

/* logic/vec_reduce_stage.sv */
module vec_reduce_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              prod_valid,
    input  vec_pkg::vec_op_t  prod_op,
    input  vec_pkg::vec3_t    prod,
    input  vec_pkg::vec3_t    addend,
    output logic              out_valid,
    output vec_pkg::vec_op_t  out_op,
    output vec_pkg::vec_res_t res
);

    logic               is_dot;  // dot or dot2 at the input
    vec_pkg::vec3_t     l1_b;    // layer 1 second operands
    vec_pkg::vec3_t     l1_sum;  // lane 0 is p0+p1 for dot ops
    fp16_pkg::float16_t l2_sum;  // full dot product
    fp16_pkg::float16_t l3_sum;  // dot doubled
    vec_pkg::vec_op_t   op_out;

    // whole stage is REDUCE_LAYERS adders deep
    logic               valid_pipe [vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES];
    vec_pkg::vec_op_t   op_pipe    [vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES];
    vec_pkg::vec3_t     scale_pipe [vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES];
    vec_pkg::vec3_t     trans_pipe [(vec_pkg::REDUCE_LAYERS-1)*fp16_pkg::ADD_STAGES];
    fp16_pkg::float16_t p2_pipe    [fp16_pkg::ADD_STAGES];  // p2 waits for layer 1
    fp16_pkg::float16_t dot_pipe   [fp16_pkg::ADD_STAGES];  // dot waits out layer 3

    assign is_dot = (prod_op == vec_pkg::op_dot) || (prod_op == vec_pkg::op_dot2);

    always_comb begin
        l1_b = addend;
        if (is_dot) begin
            l1_b[0] = prod[1];  // lane 0 pairs p0 with p1
        end
    end

    // layer 1 three lanes
    for (genvar i = 0; i < vec_pkg::VEC_LEN; i++) begin : g_l1
        fp16_add u_add (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (prod[i]),
            .b     (l1_b[i]),
            .y     (l1_sum[i])
        );
    end

    // layer 2 adds the late p2
    fp16_add u_l2 (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (l1_sum[0]),
        .b     (p2_pipe[fp16_pkg::ADD_STAGES-1]),
        .y     (l2_sum)
    );

    // layer 3 doubles
    fp16_add u_l3 (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (l2_sum),
        .b     (l2_sum),
        .y     (l3_sum)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else begin
            valid_pipe[0] <= prod_valid;
            for (int i = 1; i < vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        op_pipe[0]    <= prod_op;
        scale_pipe[0] <= prod;       // scale result skips the adders
        trans_pipe[0] <= l1_sum;     // translate result after layer 1
        p2_pipe[0]    <= prod[2];
        dot_pipe[0]   <= l2_sum;
        for (int i = 1; i < vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES; i++) begin
            op_pipe[i]    <= op_pipe[i-1];
            scale_pipe[i] <= scale_pipe[i-1];
        end
        for (int i = 1; i < (vec_pkg::REDUCE_LAYERS-1)*fp16_pkg::ADD_STAGES; i++) begin
            trans_pipe[i] <= trans_pipe[i-1];
        end
        for (int i = 1; i < fp16_pkg::ADD_STAGES; i++) begin
            p2_pipe[i]  <= p2_pipe[i-1];
            dot_pipe[i] <= dot_pipe[i-1];
        end
    end

    assign op_out    = op_pipe[vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES-1];
    assign out_op    = op_out;
    assign out_valid = valid_pipe[vec_pkg::REDUCE_LAYERS*fp16_pkg::ADD_STAGES-1];

    // unused half of the result stays zero
    always_comb begin
        res.vec    = '0;
        res.scalar = fp16_pkg::FP_ZERO;
        case (op_out)
            vec_pkg::op_scale:     res.vec    = scale_pipe[$high(scale_pipe)];
            vec_pkg::op_translate: res.vec    = trans_pipe[$high(trans_pipe)];
            vec_pkg::op_dot:       res.scalar = dot_pipe[fp16_pkg::ADD_STAGES-1];
            vec_pkg::op_dot2:      res.scalar = l3_sum;
        endcase
    end

endmodule

/* logic/vec_unit.sv */
module vec_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,  // one request per cycle, no stall
    input  vec_pkg::vec_req_t req,
    output logic              out_valid, // UNIT_LATENCY edges after in_valid
    output vec_pkg::vec_op_t  out_op,
    output vec_pkg::vec_res_t res
);

    logic             prod_valid;
    vec_pkg::vec_op_t prod_op;
    vec_pkg::vec3_t   prod;    // per lane products
    vec_pkg::vec3_t   addend;  // b delayed to match products

    // multipliers, MUL_STAGES deep
    vec_product_stage u_product (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .req        (req),
        .prod_valid (prod_valid),
        .prod_op    (prod_op),
        .prod       (prod),
        .addend     (addend)
    );

    // adder tree and alignment delays
    vec_reduce_stage u_reduce (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_valid (prod_valid),
        .prod_op    (prod_op),
        .prod       (prod),
        .addend     (addend),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .res        (res)
    );

endmodule

/* tb/tb_vec_model.svh */
`ifndef TB_VEC_MODEL_SVH
`define TB_VEC_MODEL_SVH

// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// small integer to half precision, exact up to 11 significant bits
function automatic fp16_pkg::float16_t int_to_fp(input int v);
    fp16_pkg::float16_t f;
    int m;
    int e;
    f = '0;                          // zero encodes as plus zero
    m = (v < 0) ? -v : v;
    if (m != 0) begin
        e = 0;
        for (int i = 0; i < 11; i++) begin
            if ((m >> i) != 0) begin
                e = i;               // msb position
            end
        end
        f.sign     = (v < 0);
        f.exponent = 5'(fp16_pkg::EXP_BIAS + e);
        f.mantissa = 10'(m << (10 - e));  // hidden one falls off the top
    end
    return f;
endfunction

// expected result from integer operands
function automatic vec_pkg::vec_res_t model_res(input vec_pkg::vec_op_t op,
                                                input logic [2:0] sign,
                                                input int a [vec_pkg::VEC_LEN],
                                                input int b [vec_pkg::VEC_LEN]);
    vec_pkg::vec_res_t r;
    int dot;
    int p;
    r   = '0;  // unused half stays zero
    dot = 0;
    for (int i = 0; i < vec_pkg::VEC_LEN; i++) begin
        p = sign[i] ? -(a[i] * b[i]) : a[i] * b[i];  // mask only counts for dot ops
        dot += p;
        if (op == vec_pkg::op_scale) begin
            r.vec[i] = int_to_fp(a[i] * b[i]);
        end else if (op == vec_pkg::op_translate) begin
            r.vec[i] = int_to_fp(a[i] + b[i]);
        end
    end
    if (op == vec_pkg::op_dot) begin
        r.scalar = int_to_fp(dot);
    end else if (op == vec_pkg::op_dot2) begin
        r.scalar = int_to_fp(2 * dot);
    end
    return r;
endfunction

`endif

/* tb/tb_vec_unit.sv */
module tb_vec_unit;

    `include "tb_vec_model.svh"

    typedef struct packed {
        vec_pkg::vec_op_t  op;
        vec_pkg::vec_res_t res;
        logic [31:0]       cycle;  // cycle count when driven
    } exp_t;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    vec_pkg::vec_req_t req;
    logic              out_valid;
    vec_pkg::vec_op_t  out_op;
    vec_pkg::vec_res_t res;

    logic [31:0]       cycle_cnt = '0;
    logic [15:0]       lfsr_state;
    logic              started;    // first request driven
    exp_t              exp_q [$];  // scoreboard, oldest first
    exp_t              head;
    vec_pkg::vec_req_t dir_req;
    vec_pkg::vec_res_t dir_res;
    int                waited;

    vec_unit dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .out_op    (out_op),
        .res       (res)
    );

    always #4 clk = ~clk;  // period 8

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v          = (v << 1) | 32'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
        end
        return v;
    endfunction

    function automatic int rand_operand();
        return int'(take_bits(5) % 17) - 8;  // -8 .. 8
    endfunction

    // drive for one cycle starting at a falling edge
    task automatic issue(input vec_pkg::vec_req_t r, input vec_pkg::vec_res_t exp_res);
        exp_t e;
        in_valid = 1'b1;
        req      = r;
        started  = 1'b1;
        e.op     = r.op;
        e.res    = exp_res;
        e.cycle  = cycle_cnt;
        exp_q.push_back(e);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_ints(input vec_pkg::vec_op_t op, input logic [2:0] sign,
                              input int a0, a1, a2, b0, b1, b2);
        int a [vec_pkg::VEC_LEN];
        int b [vec_pkg::VEC_LEN];
        vec_pkg::vec_req_t r;
        a[0]   = a0;
        a[1]   = a1;
        a[2]   = a2;
        b[0]   = b0;
        b[1]   = b1;
        b[2]   = b2;
        r.op   = op;
        r.sign = sign;
        for (int i = 0; i < vec_pkg::VEC_LEN; i++) begin
            r.a[i] = int_to_fp(a[i]);
            r.b[i] = int_to_fp(b[i]);
        end
        issue(r, model_res(op, sign, a, b));
    endtask

    task automatic issue_random();
        vec_pkg::vec_op_t op;
        logic [2:0] sign;
        int v [6];
        op   = vec_pkg::vec_op_t'(2'(take_bits(2)));
        sign = 3'(take_bits(3));  // also sent with scale and translate
        for (int i = 0; i < 6; i++) begin
            v[i] = rand_operand();
        end
        issue_ints(op, sign, v[0], v[1], v[2], v[3], v[4], v[5]);
    endtask

    // checks use values from before this edge
    always @(posedge clk) begin
        if (!started) begin
            assert (!out_valid) else begin
                $display("out_valid went high before the first request");
                abort_run();
            end
        end
        if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("result appeared with no request in flight");
                abort_run();
            end
            head = exp_q.pop_front();
            assert (cycle_cnt == head.cycle + vec_pkg::UNIT_LATENCY) else begin
                $display("Mismatch latency: got %h exp %h",
                         cycle_cnt - head.cycle, vec_pkg::UNIT_LATENCY);
                abort_run();
            end
            assert (out_op == head.op) else begin
                $display("Mismatch out_op: got %h exp %h", out_op, head.op);
                abort_run();
            end
            assert (res.vec == head.res.vec) else begin
                $display("Mismatch res.vec: got %h exp %h", res.vec, head.res.vec);
                abort_run();
            end
            assert (res.scalar == head.res.scalar) else begin
                $display("Mismatch res.scalar: got %h exp %h", res.scalar, head.res.scalar);
                abort_run();
            end
        end else if (exp_q.size() != 0) begin
            assert (cycle_cnt < exp_q[0].cycle + vec_pkg::UNIT_LATENCY) else begin
                $display("out_valid stayed low when a result was due");
                abort_run();
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        req        = '0;
        started    = 1'b0;
        lfsr_state = 16'd56;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);  // out_valid must stay quiet here

        issue_ints(vec_pkg::op_scale, 3'b101, 1, 2, -3, 4, -5, 6);      // mask ignored
        issue_ints(vec_pkg::op_translate, 3'b000, 1, -2, 3, -1, 5, 8);  // lane 0 cancels
        for (int m = 0; m < 8; m++) begin
            issue_ints(vec_pkg::op_dot, 3'(m), 2, -3, 4, 5, 6, -7);     // every mask
        end
        issue_ints(vec_pkg::op_dot, 3'b000, 1, 2, 3, 2, -1, 0);         // exact zero
        issue_ints(vec_pkg::op_dot2, 3'b010, 8, -8, 7, 8, 8, -6);
        issue_ints(vec_pkg::op_dot2, 3'b111, -1, 2, 0, 3, 4, 5);

        // overflow to signed infinity, exponent zero reads as zero
        dir_req           = '0;
        dir_req.op        = vec_pkg::op_scale;
        dir_req.a[0]      = 16'h7800;
        dir_req.b[0]      = 16'h7800;
        dir_req.a[1]      = 16'hF800;
        dir_req.b[1]      = 16'h7800;
        dir_req.a[2]      = 16'h0123;
        dir_req.b[2]      = 16'h4000;
        dir_res           = '0;
        dir_res.vec[0]    = 16'h7C00;
        dir_res.vec[1]    = 16'hFC00;
        dir_res.vec[2]    = 16'h0000;
        issue(dir_req, dir_res);

        for (int i = 0; i < 60; i++) begin
            issue_random();  // back to back burst
        end
        for (int i = 0; i < 30; i++) begin
            issue_random();
            repeat (int'(take_bits(2))) @(negedge clk);  // random gap
        end

        waited = 0;
        while (exp_q.size() != 0 && waited < vec_pkg::UNIT_LATENCY + 4) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for the pipeline to drain");
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+tb
logic/fp16_pkg.sv
logic/vec_pkg.sv
logic/fp16_mul.sv
logic/fp16_add.sv
logic/vec_product_stage.sv
logic/vec_reduce_stage.sv
logic/vec_unit.sv
tb/tb_vec_unit.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_vec_unit

out=$(./obj_dir/Vtb_vec_unit 2>&1 || true)
echo "$out"

if grep -q "PASS: all tests" <<< "$out"; then
    exit 0
else
    exit 1
fi
